// ==== vlog.f ====
src/lsuPkg.sv
src/laneAlign.sv
src/loadStoreUnit.sv
src/dataRam.sv
src/lsuTop.sv
sim/tbClock.sv
sim/lsu_properties.sv
sim/lsuTb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - files:
      - src/lsuPkg.sv
      - src/laneAlign.sv
      - src/loadStoreUnit.sv
      - src/dataRam.sv
      - src/lsuTop.sv
  - target: simulation
    files:
      - sim/tbClock.sv
      - sim/lsu_properties.sv
      - sim/lsuTb.sv

// ==== sim/lsuTb.sv ====
module lsuTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeoutCycles = 50;

    logic             clk;
    logic             rst;
    logic             flush;
    logic             fireStore;
    lsuPkg::lsuUop    uop;
    lsuPkg::prfRead   operands;
    logic             busy;
    lsuPkg::prfWrite  wb;
    lsuPkg::robFinish finish;

    logic [31:0] model [lsuPkg::ramWords];
    logic [31:0] lfsr;
    int          valueErrors;
    int          timeoutErrors;
    int          assertErrors;

    tbClock tbClock_inst (
        .clk(clk)
    );

    lsuTop lsuTop_inst (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .fireStore(fireStore),
        .uop(uop),
        .operands(operands),
        .busy(busy),
        .wb(wb),
        .finish(finish)
    );

    bind loadStoreUnit lsuProperties lsuProperties_inst (
        .clk(clk),
        .rst(rst),
        .state(state),
        .isLoad(isLoad),
        .busy(busy),
        .req(req),
        .wb(wb),
        .finish(finish)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextLfsr(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = nextLfsr(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] segAddr(logic [7:0] idx, logic [1:0] off);
        logic [31:0] r;
        logic [31:0] phys;
        r = randBits(2);
        phys = {22'h00_0000, idx, off};
        case (r[1:0])
            2'd1:    return lsuPkg::kseg0Base | phys;
            2'd2:    return lsuPkg::kseg1Base | phys;
            default: return phys;
        endcase
    endfunction

    function automatic int wordIndex(logic [31:0] v);
        logic [31:0] p;
        p = v;
        if (v[31:29] == 3'b100 || v[31:29] == 3'b101) begin
            p = {3'b000, v[28:0]};
        end
        return p[lsuPkg::ramIndexLsb +: lsuPkg::ramIndexWidth];
    endfunction

    function automatic logic isLoadOp(lsuPkg::lsuOp op);
        return op inside {lsuPkg::LB, lsuPkg::LH, lsuPkg::LBU, lsuPkg::LHU, lsuPkg::LW};
    endfunction

    function automatic logic misalignedOp(lsuPkg::lsuOp op, logic [31:0] v);
        case (op)
            lsuPkg::LW, lsuPkg::SW:              return v[1:0] != 2'b00;
            lsuPkg::LH, lsuPkg::LHU, lsuPkg::SH: return v[0];
            default:                             return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] loadExpect(lsuPkg::lsuOp op, logic [31:0] word,
                                               logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            lsuPkg::LB:  return {{24{b[7]}}, b};
            lsuPkg::LBU: return {24'h00_0000, b};
            lsuPkg::LH:  return {{16{h[15]}}, h};
            lsuPkg::LHU: return {16'h0000, h};
            default:     return word;
        endcase
    endfunction

    task automatic storeModel(input lsuPkg::lsuOp op, input int idx, input logic [1:0] off,
                              input logic [31:0] data);
        case (op)
            lsuPkg::SB: model[idx][8*off +: 8] = data[7:0];
            lsuPkg::SH: begin
                if (off[1]) begin
                    model[idx][31:16] = data[15:0];
                end else begin
                    model[idx][15:0] = data[15:0];
                end
            end
            lsuPkg::SW: model[idx] = data;
            default: begin
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkWb(input string name, input lsuPkg::prfWrite exp,
                           input lsuPkg::prfWrite act);
        if (exp.wen ? (act !== exp) : (act.wen !== 1'b0)) begin
            valueErrors++;
            $display("error %s wb: expected wen=%0b rd=%0d data=%h, actual wen=%0b rd=%0d data=%h",
                     name, exp.wen, exp.rd, exp.wdata, act.wen, act.rd, act.wdata);
        end
    endtask

    task automatic checkFinish(input string name, input lsuPkg::robFinish exp,
                               input lsuPkg::robFinish act);
        logic  ok;
        string expStr;
        string actStr;
        if (!exp.setFinish) begin
            ok = act.setFinish === 1'b0;
        end else if (exp.setException) begin
            ok = act === exp;
        end else begin
            ok = act.setFinish === 1'b1 && act.id === exp.id && act.setException === 1'b0;
        end
        if (!ok) begin
            valueErrors++;
            expStr = $sformatf("fin=%0b id=%0d exc=%0b code=%h bad=%h", exp.setFinish, exp.id,
                               exp.setException, exp.exceptionType, exp.badVAddr);
            actStr = $sformatf("fin=%0b id=%0d exc=%0b code=%h bad=%h", act.setFinish, act.id,
                               act.setException, act.exceptionType, act.badVAddr);
            $display("error %s finish: expected %s, actual %s", name, expStr, actStr);
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            valueErrors++;
            $display("error %s word: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkBusy(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            valueErrors++;
            $display("error %s busy: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Issue side
    ////////////////////////////////////////////////////////////////////////////

    task automatic clearIssue();
        uop = '0;
        uop.op = lsuPkg::OTHER;
        operands = '0;
    endtask

    task automatic issue(input lsuPkg::lsuOp op, input logic [31:0] vAddr,
                         input logic [31:0] data, output logic [5:0] id,
                         output logic [6:0] rd);
        logic [31:0] r;
        logic [15:0] imm;
        r = randBits(6);
        id = r[5:0];
        r = randBits(7);
        rd = r[6:0];
        r = randBits(16);
        imm = r[15:0];
        uop.valid = 1'b1;
        uop.op = op;
        uop.id = id;
        uop.imm = imm;
        uop.dstPAddr = rd;
        operands.rs0Data = vAddr - {{16{imm[15]}}, imm};
        operands.rs1Data = data;
    endtask

    task automatic waitFinish(input string name, output lsuPkg::robFinish gotFin,
                              output lsuPkg::prfWrite gotWb, output logic gotBusy);
        int n;
        n = 0;
        @(negedge clk);
        while (!finish.setFinish && n < timeoutCycles) begin
            @(negedge clk);
            n++;
        end
        if (!finish.setFinish) begin
            timeoutErrors++;
            $display("timeout: %s got no finish report within %0d cycles", name, timeoutCycles);
        end
        gotFin = finish;
        gotWb = wb;
        gotBusy = busy;
    endtask

    task automatic waitNotBusy(input string name);
        int n;
        n = 0;
        while (busy && n < timeoutCycles) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            timeoutErrors++;
            $display("timeout: %s kept the unit busy for %0d cycles", name, timeoutCycles);
        end
    endtask

    // Starts and ends 5 ns after a rising edge with the unit in Idle
    task automatic doOp(input string name, input lsuPkg::lsuOp op, input logic [31:0] vAddr,
                        input logic [31:0] data, output logic [31:0] loaded);
        lsuPkg::robFinish expFin;
        lsuPkg::robFinish gotFin;
        lsuPkg::prfWrite  expWb;
        lsuPkg::prfWrite  gotWb;
        logic             gotBusy;
        logic [5:0]       id;
        logic [6:0]       rd;
        logic             load;
        logic             bad;
        int               idx;
        load = isLoadOp(op);
        bad = misalignedOp(op, vAddr);
        idx = wordIndex(vAddr);
        issue(op, vAddr, data, id, rd);
        expFin = '0;
        expFin.setFinish = 1'b1;
        expFin.id = id;
        expFin.setException = bad;
        expFin.exceptionType = load ? lsuPkg::ExcAddressErrL : lsuPkg::ExcAddressErrS;
        expFin.badVAddr = vAddr;
        expWb = '0;
        if (load && !bad) begin
            expWb.wen = 1'b1;
            expWb.rd = rd;
            expWb.wdata = loadExpect(op, model[idx], vAddr[1:0]);
        end
        waitFinish(name, gotFin, gotWb, gotBusy);
        checkFinish(name, expFin, gotFin);
        checkWb(name, expWb, gotWb);
        // Only a completed load has released the unit when its finish goes out
        checkBusy(name, !(load && !bad), gotBusy);
        loaded = gotWb.wdata;
        if (!load && !bad) begin
            @(posedge clk);
            #5 fireStore = 1'b1;
            @(posedge clk);
            #5 fireStore = 1'b0;
            @(negedge clk);
            storeModel(op, idx, vAddr[1:0], data);
        end
        waitNotBusy(name);
        @(posedge clk);
        #5 clearIssue();
    endtask

    task automatic readBack(input string name, input logic [31:0] vAddr);
        logic [31:0] got;
        doOp({name, " readback"}, lsuPkg::LW, {vAddr[31:2], 2'b00}, 32'h0, got);
        checkWord(name, model[wordIndex(vAddr)], got);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Flush cases
    ////////////////////////////////////////////////////////////////////////////

    task automatic flushSaveBlock();
        lsuPkg::robFinish expFin;
        lsuPkg::robFinish gotFin;
        lsuPkg::prfWrite  noWb;
        lsuPkg::prfWrite  gotWb;
        logic             gotBusy;
        logic [31:0]      r;
        logic [31:0]      v;
        logic [5:0]       id;
        logic [6:0]       rd;
        r = randBits(8);
        v = segAddr(r[7:0], 2'b00);
        issue(lsuPkg::SW, v, randBits(32), id, rd);
        expFin = '0;
        expFin.setFinish = 1'b1;
        expFin.id = id;
        noWb = '0;
        waitFinish("flush in SaveBlock", gotFin, gotWb, gotBusy);
        checkFinish("flush in SaveBlock", expFin, gotFin);
        checkWb("flush in SaveBlock", noWb, gotWb);
        checkBusy("flush in SaveBlock", 1'b1, gotBusy);
        @(posedge clk);
        #5 flush = 1'b1;
        @(posedge clk);
        #5 flush = 1'b0;
        clearIssue();
        @(posedge clk);
        #5;
        // Store was dropped so the model stays untouched
        readBack("flush in SaveBlock", v);
    endtask

    task automatic flushLoadResp();
        lsuPkg::prfWrite noWb;
        lsuPkg::robFinish noFin;
        logic [31:0]      r;
        logic [31:0]      v;
        logic [31:0]      got;
        logic [5:0]       id;
        logic [6:0]       rd;
        noWb = '0;
        noFin = '0;
        r = randBits(8);
        v = segAddr(r[7:0], 2'b00);
        issue(lsuPkg::LW, v, 32'h0, id, rd);
        @(posedge clk);
        #5;
        @(posedge clk);
        #5 flush = 1'b1;
        @(negedge clk);
        checkWb("flush in LoadResp", noWb, wb);
        checkFinish("flush in LoadResp", noFin, finish);
        @(posedge clk);
        #5 flush = 1'b0;
        clearIssue();
        @(negedge clk);
        checkWb("flush in LoadResp recover", noWb, wb);
        waitNotBusy("flush in LoadResp");
        @(posedge clk);
        #5;
        doOp("load after flush", lsuPkg::LW, v, 32'h0, got);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        lsuPkg::lsuOp loadOps [5];
        lsuPkg::lsuOp storeOps [5];
        lsuPkg::lsuOp op;
        logic [31:0]  r;
        logic [31:0]  v;
        logic [31:0]  data;
        logic [31:0]  got;
        logic [31:0]  phys;
        int           k;
        loadOps = '{lsuPkg::LB, lsuPkg::LH, lsuPkg::LBU, lsuPkg::LHU, lsuPkg::LW};
        storeOps = '{lsuPkg::SB, lsuPkg::SH, lsuPkg::SW, lsuPkg::SWL, lsuPkg::SWR};
        lfsr = 32'h1550f635;
        valueErrors = 0;
        timeoutErrors = 0;
        rst = 1'b1;
        flush = 1'b0;
        fireStore = 1'b0;
        clearIssue();
        repeat (3) @(posedge clk);
        #5 rst = 1'b0;
        @(posedge clk);
        #5;

        // RAM content is unknown until every word is written once
        for (int w = 0; w < lsuPkg::ramWords; w++) begin
            doOp("fill", lsuPkg::SW, segAddr(w[7:0], 2'b00), randBits(32), got);
        end

        // Every load kind at every offset including misaligned ones
        foreach (loadOps[i]) begin
            for (int off = 0; off < 4; off++) begin
                r = randBits(8);
                v = segAddr(r[7:0], off[1:0]);
                doOp($sformatf("%s off %0d", loadOps[i].name(), off), loadOps[i], v,
                     32'h0, got);
            end
        end

        foreach (storeOps[i]) begin
            for (int off = 0; off < 4; off++) begin
                r = randBits(8);
                v = segAddr(r[7:0], off[1:0]);
                doOp($sformatf("%s off %0d", storeOps[i].name(), off), storeOps[i], v,
                     randBits(32), got);
                readBack($sformatf("%s off %0d", storeOps[i].name(), off), v);
            end
        end

        // Same word through kseg0, kseg1 and unmapped
        r = randBits(8);
        phys = {22'h00_0000, r[7:0], 2'b00};
        data = randBits(32);
        doOp("alias store", lsuPkg::SW, lsuPkg::kseg0Base | phys, data, got);
        doOp("alias kseg1", lsuPkg::LW, lsuPkg::kseg1Base | phys, 32'h0, got);
        checkWord("alias kseg1", data, got);
        doOp("alias unmapped", lsuPkg::LW, phys, 32'h0, got);
        checkWord("alias unmapped", data, got);

        repeat (4) begin
            flushSaveBlock();
            flushLoadResp();
        end

        repeat (200) begin
            k = randBits(4) % 10;
            op = lsuPkg::lsuOp'(k[3:0]);
            r = randBits(10);
            v = segAddr(r[9:2], r[1:0]);
            doOp($sformatf("random %s", op.name()), op, v, randBits(32), got);
        end

        assertErrors = lsuTop_inst.loadStoreUnit_inst.lsuProperties_inst.assertFails;
        $display("Error counts: %0d value, %0d timeout, %0d assertion",
                 valueErrors, timeoutErrors, assertErrors);
        if (valueErrors == 0 && timeoutErrors == 0 && assertErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sim/lsu_properties.sv ====
module lsuProperties (
    input logic              clk,
    input logic              rst,
    input logic [2:0]        state,
    input logic              isLoad,
    input logic              busy,
    input lsuPkg::memReq     req,
    input lsuPkg::prfWrite   wb,
    input lsuPkg::robFinish  finish
);

    timeunit 1ns;
    timeprecision 1ps;

    // Idle is the first state encoding of the unit
    localparam logic [2:0] idleState = 3'd0;

    int assertFails = 0;

    noRequestInIdle: assert property (
        @(posedge clk) disable iff (rst)
        state == idleState |-> !req.valid
    ) else begin
        assertFails++;
        $error("memory request valid while the unit is in Idle");
    end

    // Load writeback and load finish report go out in the same cycle
    loadWbWithFinish: assert property (
        @(posedge clk) disable iff (rst)
        wb.wen == (finish.setFinish && isLoad && !finish.setException)
    ) else begin
        assertFails++;
        $error("load writeback and load finish report are not paired");
    end

    notBusyAfterReset: assert property (
        @(posedge clk)
        $fell(rst) |-> !busy
    ) else begin
        assertFails++;
        $error("unit busy in the first cycle after reset");
    end

endmodule

// ==== sim/tbClock.sv ====
module tbClock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam time halfPeriod = 50ns;

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

// ==== src/lsuTop.sv ====
module lsuTop (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             fireStore,
    input  lsuPkg::lsuUop    uop,
    input  lsuPkg::prfRead   operands,
    output logic             busy,
    output lsuPkg::prfWrite  wb,
    output lsuPkg::robFinish finish
);

    lsuPkg::memReq  req;
    lsuPkg::memResp resp;
    logic           respReady;
    logic           reqReady;

    loadStoreUnit loadStoreUnit_inst (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .fireStore(fireStore),
        .uop(uop),
        .operands(operands),
        .busy(busy),
        .wb(wb),
        .finish(finish),
        .req(req),
        .respReady(respReady),
        .reqReady(reqReady),
        .resp(resp)
    );

    dataRam dataRam_inst (
        .clk(clk),
        .rst(rst),
        .req(req),
        .respReady(respReady),
        .reqReady(reqReady),
        .resp(resp)
    );

endmodule

// ==== src/dataRam.sv ====
module dataRam (
    input  logic           clk,
    input  logic           rst,
    input  lsuPkg::memReq  req,
    input  logic           respReady,
    output logic           reqReady,
    output lsuPkg::memResp resp
);

    logic [31:0] mem [lsuPkg::ramWords];
    logic [lsuPkg::ramIndexWidth-1:0] index;
    logic readFire;
    logic writeFire;

    assign index = req.addr[lsuPkg::ramIndexLsb +: lsuPkg::ramIndexWidth];

    // One response slot, so no new request while it is occupied
    assign reqReady = !resp.valid;
    assign readFire = req.valid && reqReady && !req.writeEn;
    assign writeFire = req.valid && reqReady && req.writeEn;

    always_ff @(posedge clk) begin
        if (writeFire) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strobe[b]) begin
                    mem[index][8*b +: 8] <= req.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
            resp.data <= '0;
        end else if (readFire) begin
            resp.valid <= 1'b1;
            resp.data <= mem[index];
        end else if (respReady) begin
            resp.valid <= 1'b0;
        end
    end

endmodule

// ==== src/loadStoreUnit.sv ====
module loadStoreUnit (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             fireStore,
    input  lsuPkg::lsuUop    uop,
    input  lsuPkg::prfRead   operands,
    output logic             busy,
    output lsuPkg::prfWrite  wb,
    output lsuPkg::robFinish finish,
    output lsuPkg::memReq    req,
    output logic             respReady,
    input  logic             reqReady,
    input  lsuPkg::memResp   resp
);

    typedef enum logic [2:0] {
        Idle,
        Exception,
        LoadReq,
        LoadResp,
        SaveBlock,
        SaveFire,
        Recover,
        Reset
    } lsuState;

    lsuState        state;
    lsuState        nextState;
    lsuPkg::lsuUop  curUop;
    lsuPkg::prfRead curOps;
    lsuPkg::lsuUop  heldUop;
    lsuPkg::prfRead heldOps;
    logic           holdStore;
    logic           excRetired;
    logic [31:0]    vAddr;
    logic [31:0]    pAddr;
    logic           isLoad;
    logic           isStore;
    logic           misaligned;
    logic           loadDone;
    logic [3:0]     storeStrobe;
    logic [31:0]    storeData;
    logic [31:0]    loadValue;

    ////////////////////////////////////////////////////////////////////////////
    // Decode and address
    ////////////////////////////////////////////////////////////////////////////

    assign curUop = holdStore ? heldUop : uop;
    assign curOps = holdStore ? heldOps : operands;

    assign vAddr = curOps.rs0Data + {{16{curUop.imm[15]}}, curUop.imm};

    assign isLoad = curUop.valid && curUop.op inside {lsuPkg::LB, lsuPkg::LH, lsuPkg::LBU,
                                                       lsuPkg::LHU, lsuPkg::LW};
    // SWL and SWR pass through the store path with an empty strobe
    assign isStore = curUop.valid && curUop.op inside {lsuPkg::SB, lsuPkg::SH, lsuPkg::SW,
                                                        lsuPkg::SWL, lsuPkg::SWR};

    always_comb begin
        misaligned = 1'b0;
        if (curUop.valid) begin
            case (curUop.op)
                lsuPkg::LW, lsuPkg::SW:              misaligned = |vAddr[1:0];
                lsuPkg::LH, lsuPkg::LHU, lsuPkg::SH: misaligned = vAddr[0];
                default:                             misaligned = 1'b0;
            endcase
        end
    end

    // Unmapped segments only, no TLB
    always_comb begin
        if (vAddr >= lsuPkg::kseg0Base && vAddr < lsuPkg::kseg0Base + lsuPkg::segSize) begin
            pAddr = vAddr - lsuPkg::kseg0Base;
        end else if (vAddr >= lsuPkg::kseg1Base && vAddr < lsuPkg::kseg1Base + lsuPkg::segSize) begin
            pAddr = vAddr - lsuPkg::kseg1Base;
        end else begin
            pAddr = vAddr;
        end
    end

    laneAlign laneAlign_inst (
        .op(curUop.op),
        .addrLow(vAddr[1:0]),
        .storeData(curOps.rs1Data),
        .loadWord(resp.data),
        .strobe(storeStrobe),
        .placedData(storeData),
        .loadValue(loadValue)
    );

    assign loadDone = resp.valid && !flush;

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Reset;
            excRetired <= 1'b0;
        end else begin
            state <= nextState;
            // Faulting uop is still on the issue port for one more cycle
            excRetired <= (state == Exception);
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (flush) begin
                    nextState = Reset;
                end else if (excRetired) begin
                    nextState = Idle;
                end else if (misaligned) begin
                    nextState = Exception;
                end else if (isLoad) begin
                    nextState = LoadReq;
                end else if (isStore) begin
                    nextState = SaveBlock;
                end
            end
            Exception: nextState = flush ? Reset : Idle;
            LoadReq: begin
                if (flush) begin
                    nextState = Reset;
                end else if (reqReady) begin
                    nextState = LoadResp;
                end
            end
            LoadResp: begin
                if (flush) begin
                    nextState = Recover;
                end else if (resp.valid) begin
                    nextState = Idle;
                end
            end
            SaveBlock: begin
                if (flush) begin
                    nextState = Reset;
                end else if (fireStore) begin
                    nextState = SaveFire;
                end
            end
            // A fired store is past commit and always finishes
            SaveFire: nextState = reqReady ? Idle : SaveFire;
            Recover:  nextState = resp.valid ? Idle : Recover;
            Reset:    nextState = flush ? Reset : Idle;
            default:  nextState = Reset;
        endcase
    end

    // Keep the store alive when the issue side is flushed under it
    always_ff @(posedge clk) begin
        if (rst) begin
            holdStore <= 1'b0;
        end else if (state == SaveFire && reqReady) begin
            holdStore <= 1'b0;
        end else if (state == SaveFire && flush) begin
            holdStore <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == SaveFire && flush && !holdStore) begin
            heldUop <= uop;
            heldOps <= operands;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        busy = 1'b0;
        respReady = 1'b0;
        req.valid = 1'b0;
        req.writeEn = 1'b0;
        req.addr = pAddr;
        req.data = storeData;
        req.strobe = storeStrobe;
        finish.setFinish = 1'b0;
        finish.id = curUop.id;
        finish.setException = 1'b0;
        finish.exceptionType = lsuPkg::ExcAddressErrL;
        finish.badVAddr = vAddr;
        wb.wen = 1'b0;
        wb.rd = curUop.dstPAddr;
        wb.wdata = loadValue;
        case (state)
            Idle: begin
                busy = !excRetired && (isLoad || isStore);
                // Stores finish early, memory is written after commit
                finish.setFinish = !excRetired && isStore && !misaligned;
            end
            Exception: begin
                busy = 1'b1;
                finish.setFinish = 1'b1;
                finish.setException = 1'b1;
                finish.exceptionType = isLoad ? lsuPkg::ExcAddressErrL : lsuPkg::ExcAddressErrS;
            end
            LoadReq: begin
                busy = 1'b1;
                req.valid = !flush;
                req.addr = {pAddr[31:2], 2'b00};
            end
            LoadResp: begin
                // On flush the response is left for Recover to drain
                respReady = !flush;
                busy = !loadDone;
                finish.setFinish = loadDone;
                wb.wen = loadDone;
            end
            SaveBlock: begin
                busy = 1'b1;
            end
            SaveFire: begin
                busy = !reqReady;
                req.valid = 1'b1;
                req.writeEn = 1'b1;
            end
            Recover: begin
                respReady = 1'b1;
                busy = !resp.valid;
            end
            default: begin
                busy = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/laneAlign.sv ====
module laneAlign (
    input  lsuPkg::lsuOp op,
    input  logic [1:0]   addrLow,
    input  logic [31:0]  storeData,
    input  logic [31:0]  loadWord,
    output logic [3:0]   strobe,
    output logic [31:0]  placedData,
    output logic [31:0]  loadValue
);

    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    // Little-endian lane select
    assign loadByte = loadWord[{addrLow, 3'b000} +: 8];
    assign loadHalf = addrLow[1] ? loadWord[31:16] : loadWord[15:0];

    // Store data moves up to its lane
    always_comb begin
        strobe = 4'b0000;
        placedData = storeData;
        case (op)
            lsuPkg::SB: begin
                strobe = 4'b0001 << addrLow;
                placedData = storeData << {addrLow, 3'b000};
            end
            lsuPkg::SH: begin
                strobe = addrLow[1] ? 4'b1100 : 4'b0011;
                placedData = addrLow[1] ? {storeData[15:0], 16'h0000} : storeData;
            end
            lsuPkg::SW: begin
                strobe = 4'b1111;
            end
            default: begin
                strobe = 4'b0000;
            end
        endcase
    end

    // Load data moves down and gets extended
    always_comb begin
        case (op)
            lsuPkg::LB:  loadValue = {{24{loadByte[7]}}, loadByte};
            lsuPkg::LH:  loadValue = {{16{loadHalf[15]}}, loadHalf};
            lsuPkg::LBU: loadValue = {24'h00_0000, loadByte};
            lsuPkg::LHU: loadValue = {16'h0000, loadHalf};
            default:     loadValue = loadWord;
        endcase
    end

endmodule

// ==== src/lsuPkg.sv ====
package lsuPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data memory and address map
    ////////////////////////////////////////////////////////////////////////////

    localparam int ramWords = 256;
    localparam int ramIndexLsb = 2;
    localparam int ramIndexWidth = $clog2(ramWords);

    // kseg0 is cached and kseg1 uncached, both map to the low 512 MB
    localparam logic [31:0] kseg0Base = 32'h8000_0000;
    localparam logic [31:0] kseg1Base = 32'hA000_0000;
    localparam logic [31:0] segSize = 32'h2000_0000;

    ////////////////////////////////////////////////////////////////////////////
    // Micro-op and exception encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        LB,
        LH,
        LBU,
        LHU,
        LW,
        SB,
        SH,
        SW,
        SWL,
        SWR,
        OTHER
    } lsuOp;

    // Cause codes as in the CP0 Cause register
    typedef enum logic [4:0] {
        ExcAddressErrL = 5'h04,
        ExcAddressErrS = 5'h05
    } excCode;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        lsuOp        op;
        logic [5:0]  id;
        logic [15:0] imm;
        logic [6:0]  dstPAddr;
    } lsuUop;

    typedef struct packed {
        logic [31:0] rs0Data;
        logic [31:0] rs1Data;
    } prfRead;

    typedef struct packed {
        logic        wen;
        logic [6:0]  rd;
        logic [31:0] wdata;
    } prfWrite;

    typedef struct packed {
        logic        setFinish;
        logic [5:0]  id;
        logic        setException;
        excCode      exceptionType;
        logic [31:0] badVAddr;
    } robFinish;

    // Request and response channels of the data memory
    typedef struct packed {
        logic        valid;
        logic        writeEn;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strobe;
    } memReq;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } memResp;

endpackage
